// ==== common/mmu_pkg.sv ====
// MMU types for a MIPS32 style TLB; fields follow PageMask/EntryHi/EntryLo, no 64-bit or MIPS16
`default_nettype none

package mmu_pkg;

    // One paired TLB entry, vpn2 and pfns stored already masked
    typedef struct packed {
        logic [11:0] mask;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic [7:0] asid;
        logic       kernel_mode;
        logic       erl;
        logic       kseg0_cached;
    } cp0_state_t;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_PROBE
    } mgmt_op_e;

    typedef struct packed {
        mgmt_op_e    op;
        logic [7:0]  index;
        logic [11:0] mask;
        logic [31:0] entryhi;
        logic [31:0] entrylo0;
        logic [31:0] entrylo1;
    } mgmt_req_t;

    // Bit 31 of probe_index flags a probe miss
    typedef struct packed {
        logic [11:0] mask;
        logic [31:0] entryhi;
        logic [31:0] entrylo0;
        logic [31:0] entrylo1;
        logic [31:0] probe_index;
    } mgmt_rsp_t;

    typedef struct packed {
        logic        valid;
        logic        store;
        logic [31:0] vaddr;
    } lookup_req_t;

    typedef struct packed {
        logic        valid;
        logic        store;
        logic [31:0] vaddr;
        logic [31:0] paddr;
        logic        hit;
        logic        pvalid;
        logic        dirty;
        logic        cached;
        logic        addr_err;
    } lookup_rsp_t;

    typedef enum logic [2:0] {
        SEG_USEG,
        SEG_KSEG0,
        SEG_KSEG1,
        SEG_KSSEG,
        SEG_KSEG3
    } addr_seg_e;

    typedef enum logic [3:0] {
        EXC_NONE,
        EXC_ADEL_I,
        EXC_TLBL_REFILL_I,
        EXC_TLBL_INV_I,
        EXC_ADEL_D,
        EXC_ADES_D,
        EXC_TLB_REFILL_D,
        EXC_TLB_INV_D,
        EXC_TLB_MOD
    } mmu_exc_e;

endpackage

`default_nettype wire

// ==== design/tlb/tlb_entry_array.sv ====
// TLB entry storage; written entries must already be masked, reset leaves no valid entry
`timescale 1ns/1ns
`default_nettype none

module tlb_entry_array
    import mmu_pkg::*;
#(
    parameter int TLB_IDX_BITS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  we_i,
    input  logic [TLB_IDX_BITS-1:0]               idx_i,
    input  tlb_entry_t                            wdata_i,
    output tlb_entry_t                            rdata_o,
    output tlb_entry_t [2**TLB_IDX_BITS-1:0]      entries_o
);

    localparam int TLB_NUM = 2**TLB_IDX_BITS;

    tlb_entry_t [TLB_NUM-1:0] entries_q;

    // Cleared entries keep C at 3 so a later read shows cacheable
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < TLB_NUM; n++) begin
                entries_q[n]    <= '0;
                entries_q[n].c0 <= 3'd3;
                entries_q[n].c1 <= 3'd3;
            end
        end else if (we_i) begin
            entries_q[idx_i] <= wdata_i;
        end
    end

    // Combinational read port for CP0
    assign rdata_o = entries_q[idx_i];

    // Whole array goes to the probe logic and both matchers
    assign entries_o = entries_q;

endmodule

`default_nettype wire

// ==== design/tlb/tlb_mgmt_ctrl.sv ====
// CP0 side of the TLB with four-phase req/ack; TLBWI, TLBR and TLBP only, no random write
`timescale 1ns/1ns
`default_nettype none

module tlb_mgmt_ctrl
    import mmu_pkg::*;
#(
    parameter int TLB_IDX_BITS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  req_i,
    input  mgmt_req_t                             req_data_i,
    output logic                                  ack_o,
    output mgmt_rsp_t                             rsp_o,
    output logic                                  we_o,
    output logic [TLB_IDX_BITS-1:0]               idx_o,
    output tlb_entry_t                            wdata_o,
    input  tlb_entry_t                            rdata_i,
    input  tlb_entry_t [2**TLB_IDX_BITS-1:0]      entries_i
);

    localparam int TLB_NUM = 2**TLB_IDX_BITS;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic        start;
    logic [31:0] probe_index;

    // Operation runs on the edge that raises ack
    assign start = (state_q == IDLE) && req_i;
    assign ack_o = (state_q != IDLE);
    assign we_o  = start && (req_data_i.op == OP_WRITE);
    assign idx_o = req_data_i.index[TLB_IDX_BITS-1:0];

    // Pack EntryHi/EntryLo into an entry, pair is global only if both halves are
    always_comb begin
        wdata_o.mask = req_data_i.mask;
        wdata_o.vpn2 = req_data_i.entryhi[31:13] & ~{7'b0, req_data_i.mask};
        wdata_o.asid = req_data_i.entryhi[7:0];
        wdata_o.g    = req_data_i.entrylo0[0] & req_data_i.entrylo1[0];
        wdata_o.pfn0 = req_data_i.entrylo0[25:6] & ~{8'b0, req_data_i.mask};
        wdata_o.c0   = req_data_i.entrylo0[5:3];
        wdata_o.d0   = req_data_i.entrylo0[2];
        wdata_o.v0   = req_data_i.entrylo0[1];
        wdata_o.pfn1 = req_data_i.entrylo1[25:6] & ~{8'b0, req_data_i.mask};
        wdata_o.c1   = req_data_i.entrylo1[5:3];
        wdata_o.d1   = req_data_i.entrylo1[2];
        wdata_o.v1   = req_data_i.entrylo1[1];
    end

    // Probe scans downwards so the lowest match is kept
    always_comb begin
        logic                    found;
        logic [TLB_IDX_BITS-1:0] hit_idx;
        found   = 1'b0;
        hit_idx = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (((req_data_i.entryhi[31:13] & ~{7'b0, entries_i[i].mask}) == entries_i[i].vpn2)
                && (entries_i[i].g || (entries_i[i].asid == req_data_i.entryhi[7:0]))) begin
                found   = 1'b1;
                hit_idx = TLB_IDX_BITS'(i);
            end
        end
        probe_index = found ? {{(32 - TLB_IDX_BITS){1'b0}}, hit_idx} : 32'h8000_0000;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                state_d = req_i ? WAIT_DROP : IDLE;
            end
            WAIT_DROP: begin
                if (!req_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
        if (start) begin
            case (req_data_i.op)
                OP_READ: begin
                    rsp_o.mask     <= rdata_i.mask;
                    rsp_o.entryhi  <= {rdata_i.vpn2, 5'b0, rdata_i.asid};
                    rsp_o.entrylo0 <= {6'b0, rdata_i.pfn0, rdata_i.c0, rdata_i.d0,
                                       rdata_i.v0, rdata_i.g};
                    rsp_o.entrylo1 <= {6'b0, rdata_i.pfn1, rdata_i.c1, rdata_i.d1,
                                       rdata_i.v1, rdata_i.g};
                end
                OP_PROBE: begin
                    rsp_o.probe_index <= probe_index;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/tlb/tlb_lookup.sv ====
// One translation port, result one cycle after the request; cached means C equals 3
`timescale 1ns/1ns
`default_nettype none

module tlb_lookup
    import mmu_pkg::*;
#(
    parameter int TLB_IDX_BITS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  lookup_req_t                           req_i,
    input  cp0_state_t                            cp0_i,
    input  tlb_entry_t [2**TLB_IDX_BITS-1:0]      entries_i,
    output lookup_rsp_t                           rsp_o
);

    localparam int TLB_NUM = 2**TLB_IDX_BITS;

    addr_seg_e   seg;
    logic        mapped;
    logic        addr_err;
    logic        tlb_hit;
    logic [31:0] tlb_paddr;
    logic        tlb_v;
    logic        tlb_d;
    logic [2:0]  tlb_c;
    logic [31:0] paddr;
    logic        hit;
    logic        pvalid;
    logic        dirty;
    logic        cached;

    always_comb begin
        case (req_i.vaddr[31:29])
            3'b100:  seg = SEG_KSEG0;
            3'b101:  seg = SEG_KSEG1;
            3'b110:  seg = SEG_KSSEG;
            3'b111:  seg = SEG_KSEG3;
            default: seg = SEG_USEG;
        endcase
    end

    // User mode sees useg only
    always_comb begin
        mapped   = 1'b1;
        addr_err = 1'b0;
        if (!cp0_i.kernel_mode) begin
            addr_err = (seg != SEG_USEG);
        end else if ((seg == SEG_KSEG0) || (seg == SEG_KSEG1)) begin
            mapped = 1'b0;
        end else if ((seg == SEG_USEG) && cp0_i.erl) begin
            mapped = 1'b0;
        end
    end

    // Associative match, first hit wins
    always_comb begin
        logic [18:0] vpn2_m;
        logic        odd;
        logic [19:0] pfn;
        tlb_hit   = 1'b0;
        tlb_paddr = '0;
        tlb_v     = 1'b0;
        tlb_d     = 1'b0;
        tlb_c     = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            vpn2_m = req_i.vaddr[31:13] & ~{7'b0, entries_i[i].mask};
            // Even/odd select is the vaddr bit just above the mask
            odd = |(req_i.vaddr[24:12]
                    & ({entries_i[i].mask, 1'b1} ^ {1'b0, entries_i[i].mask}));
            pfn = odd ? entries_i[i].pfn1 : entries_i[i].pfn0;
            if (!tlb_hit && (vpn2_m == entries_i[i].vpn2)
                && (entries_i[i].g || (entries_i[i].asid == cp0_i.asid))) begin
                tlb_hit   = 1'b1;
                tlb_paddr = {pfn, 12'b0}
                            | (req_i.vaddr & {8'b0, entries_i[i].mask, 12'hfff});
                tlb_v     = odd ? entries_i[i].v1 : entries_i[i].v0;
                tlb_d     = odd ? entries_i[i].d1 : entries_i[i].d0;
                tlb_c     = odd ? entries_i[i].c1 : entries_i[i].c0;
            end
        end
    end

    always_comb begin
        if (mapped) begin
            paddr  = tlb_paddr;
            hit    = tlb_hit;
            pvalid = tlb_v;
            dirty  = tlb_d;
            cached = (tlb_c == 3'd3);
        end else begin
            paddr  = {3'b0, req_i.vaddr[28:0]};
            hit    = 1'b1;
            pvalid = 1'b1;
            dirty  = 1'b1;
            cached = (seg == SEG_KSEG0) && cp0_i.kseg0_cached;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_o.valid <= 1'b0;
        end else begin
            rsp_o.valid <= req_i.valid;
        end
        if (req_i.valid) begin
            rsp_o.store    <= req_i.store;
            rsp_o.vaddr    <= req_i.vaddr;
            rsp_o.paddr    <= paddr;
            rsp_o.hit      <= hit;
            rsp_o.pvalid   <= pvalid;
            rsp_o.dirty    <= dirty;
            rsp_o.cached   <= cached;
            rsp_o.addr_err <= addr_err;
        end
    end

endmodule

`default_nettype wire

// ==== design/mmu_fault_merge.sv ====
// Single exception out of both ports; a fetch fault always beats a data fault
`timescale 1ns/1ns
`default_nettype none

module mmu_fault_merge
    import mmu_pkg::*;
(
    input  lookup_rsp_t fetch_i,
    input  lookup_rsp_t data_i,
    output mmu_exc_e    exc_o,
    output logic [31:0] badvaddr_o
);

    mmu_exc_e fetch_exc;
    mmu_exc_e data_exc;

    always_comb begin
        fetch_exc = EXC_NONE;
        if (fetch_i.valid) begin
            if (fetch_i.addr_err) begin
                fetch_exc = EXC_ADEL_I;
            end else if (!fetch_i.hit) begin
                fetch_exc = EXC_TLBL_REFILL_I;
            end else if (!fetch_i.pvalid) begin
                fetch_exc = EXC_TLBL_INV_I;
            end
        end
    end

    // Modified only applies to stores
    always_comb begin
        data_exc = EXC_NONE;
        if (data_i.valid) begin
            if (data_i.addr_err) begin
                data_exc = data_i.store ? EXC_ADES_D : EXC_ADEL_D;
            end else if (!data_i.hit) begin
                data_exc = EXC_TLB_REFILL_D;
            end else if (!data_i.pvalid) begin
                data_exc = EXC_TLB_INV_D;
            end else if (data_i.store && !data_i.dirty) begin
                data_exc = EXC_TLB_MOD;
            end
        end
    end

    always_comb begin
        if (fetch_exc != EXC_NONE) begin
            exc_o      = fetch_exc;
            badvaddr_o = fetch_i.vaddr;
        end else if (data_exc != EXC_NONE) begin
            exc_o      = data_exc;
            badvaddr_o = data_i.vaddr;
        end else begin
            exc_o      = EXC_NONE;
            badvaddr_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/mmu_top.sv ====
// MMU top with shared TLB and two lookup ports; TLB_IDX_BITS sets the entry count
`timescale 1ns/1ns
`default_nettype none

module mmu_top
    import mmu_pkg::*;
#(
    parameter int TLB_IDX_BITS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mgmt_req_valid_i,
    input  mgmt_req_t   mgmt_req_i,
    output logic        mgmt_ack_o,
    output mgmt_rsp_t   mgmt_rsp_o,
    input  cp0_state_t  cp0_i,
    input  lookup_req_t fetch_req_i,
    input  lookup_req_t data_req_i,
    output lookup_rsp_t fetch_rsp_o,
    output lookup_rsp_t data_rsp_o,
    output mmu_exc_e    exc_o,
    output logic [31:0] badvaddr_o
);

    logic                                 tlb_we;
    logic [TLB_IDX_BITS-1:0]              tlb_idx;
    tlb_entry_t                           tlb_wdata;
    tlb_entry_t                           tlb_rdata;
    tlb_entry_t [2**TLB_IDX_BITS-1:0]     tlb_entries;
    lookup_rsp_t                          fetch_rsp;
    lookup_rsp_t                          data_rsp;

    tlb_entry_array #(
        .TLB_IDX_BITS(TLB_IDX_BITS)
    ) i_tlb_entry_array (
        .clk      (clk),
        .rst      (rst),
        .we_i     (tlb_we),
        .idx_i    (tlb_idx),
        .wdata_i  (tlb_wdata),
        .rdata_o  (tlb_rdata),
        .entries_o(tlb_entries)
    );

    tlb_mgmt_ctrl #(
        .TLB_IDX_BITS(TLB_IDX_BITS)
    ) i_tlb_mgmt_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req_i     (mgmt_req_valid_i),
        .req_data_i(mgmt_req_i),
        .ack_o     (mgmt_ack_o),
        .rsp_o     (mgmt_rsp_o),
        .we_o      (tlb_we),
        .idx_o     (tlb_idx),
        .wdata_o   (tlb_wdata),
        .rdata_i   (tlb_rdata),
        .entries_i (tlb_entries)
    );

    tlb_lookup #(
        .TLB_IDX_BITS(TLB_IDX_BITS)
    ) i_fetch_lookup (
        .clk      (clk),
        .rst      (rst),
        .req_i    (fetch_req_i),
        .cp0_i    (cp0_i),
        .entries_i(tlb_entries),
        .rsp_o    (fetch_rsp)
    );

    tlb_lookup #(
        .TLB_IDX_BITS(TLB_IDX_BITS)
    ) i_data_lookup (
        .clk      (clk),
        .rst      (rst),
        .req_i    (data_req_i),
        .cp0_i    (cp0_i),
        .entries_i(tlb_entries),
        .rsp_o    (data_rsp)
    );

    mmu_fault_merge i_mmu_fault_merge (
        .fetch_i   (fetch_rsp),
        .data_i    (data_rsp),
        .exc_o     (exc_o),
        .badvaddr_o(badvaddr_o)
    );

    assign fetch_rsp_o = fetch_rsp;
    assign data_rsp_o  = data_rsp;

endmodule

`default_nettype wire

// ==== bench/mmu_tb.sv ====
// MMU testbench; run from the project root so bench/mmu_cases.txt is found, TLB has 16 entries
`timescale 1ns/1ns
`default_nettype none

module mmu_tb;
    import mmu_pkg::*;

    localparam int TLB_IDX_BITS = 4;
    localparam int ACK_TIMEOUT  = 20;
    localparam int CASE_CYCLES  = 40;
    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        rst;
    logic        mgmt_req_valid;
    mgmt_req_t   mgmt_req;
    logic        mgmt_ack;
    mgmt_rsp_t   mgmt_rsp;
    cp0_state_t  cp0;
    lookup_req_t fetch_req;
    lookup_req_t data_req;
    lookup_rsp_t fetch_rsp;
    lookup_rsp_t data_rsp;
    mmu_exc_e    exc;
    logic [31:0] badvaddr;

    logic [7:0]  kinds[$];
    logic [31:0] fields[$];
    int          num_cases;
    bit          cases_loaded;
    integer      seed;

    mmu_top #(
        .TLB_IDX_BITS(TLB_IDX_BITS)
    ) i_mmu_top (
        .clk             (clk),
        .rst             (rst),
        .mgmt_req_valid_i(mgmt_req_valid),
        .mgmt_req_i      (mgmt_req),
        .mgmt_ack_o      (mgmt_ack),
        .mgmt_rsp_o      (mgmt_rsp),
        .cp0_i           (cp0),
        .fetch_req_i     (fetch_req),
        .data_req_i      (data_req),
        .fetch_rsp_o     (fetch_rsp),
        .data_rsp_o      (data_rsp),
        .exc_o           (exc),
        .badvaddr_o      (badvaddr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("error at %0t ns: %s expected %h, got %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic store_case(input logic [7:0] kind, input logic [31:0] vals[16],
                              input int count, input integer code);
        assert (code == count) else begin
            report_failure($sformatf("Malformed line of kind %c in the case file", kind));
        end
        kinds.push_back(kind);
        for (int k = 0; k < count; k++) begin
            fields.push_back(vals[k]);
        end
        num_cases++;
    endtask

    task automatic load_cases();
        integer              fd;
        integer              code;
        logic [7:0]          kind;
        logic [8*128-1:0]    skip_line;
        logic [31:0]         v[16];
        fd = $fopen("bench/mmu_cases.txt", "r");
        assert (fd != 0) else begin
            report_failure("Could not open the case file bench/mmu_cases.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                break;
            end
            case (kind)
                "#": begin
                    code = $fgets(skip_line, fd);
                end
                "W", "R": begin
                    code = $fscanf(fd, "%h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]);
                    store_case(kind, v, 5, code);
                end
                "P": begin
                    code = $fscanf(fd, "%h %h", v[0], v[1]);
                    store_case(kind, v, 2, code);
                end
                "L", "B": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %b %h %b %h %h",
                                   v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                   v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
                    store_case(kind, v, 16, code);
                end
                default: begin
                    report_failure($sformatf("Unknown case kind %c in the case file", kind));
                end
            endcase
        end
        $fclose(fd);
    endtask

    function automatic logic [31:0] next_field();
        return fields.pop_front();
    endfunction

    task automatic idle_cycles();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Polls ack 1 ns after each edge
    task automatic wait_ack(input logic level, input string phase);
        int n;
        n = 0;
        while (mgmt_ack !== level) begin
            assert (n < ACK_TIMEOUT) else begin
                report_failure($sformatf("Handshake timed out, ack did not %s", phase));
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic do_mgmt(input logic [7:0] kind);
        mgmt_req_t req;
        req = '0;
        case (kind)
            "W": begin
                req.op       = OP_WRITE;
                req.index    = 8'(next_field());
                req.mask     = 12'(next_field());
                req.entryhi  = next_field();
                req.entrylo0 = next_field();
                req.entrylo1 = next_field();
            end
            "R": begin
                req.op    = OP_READ;
                req.index = 8'(next_field());
            end
            default: begin
                req.op      = OP_PROBE;
                req.entryhi = next_field();
            end
        endcase
        wait_ack(1'b0, "fall before the next request");
        mgmt_req       = req;
        mgmt_req_valid = 1'b1;
        wait_ack(1'b1, "rise after the request");
        if (kind == "R") begin
            check_value("mgmt_rsp_o.mask", next_field(), {20'b0, mgmt_rsp.mask});
            check_value("mgmt_rsp_o.entryhi", next_field(), mgmt_rsp.entryhi);
            check_value("mgmt_rsp_o.entrylo0", next_field(), mgmt_rsp.entrylo0);
            check_value("mgmt_rsp_o.entrylo1", next_field(), mgmt_rsp.entrylo1);
        end else if (kind == "P") begin
            check_value("mgmt_rsp_o.probe_index", next_field(), mgmt_rsp.probe_index);
        end
        mgmt_req_valid = 1'b0;
    endtask

    // Flags are hit, pvalid, dirty, cached, addr_err from the top bit down
    task automatic check_port(input string name, input logic exp_valid,
                              input logic exp_store, input logic [31:0] exp_vaddr,
                              input logic [31:0] exp_paddr, input logic [4:0] exp_flags,
                              input lookup_rsp_t rsp);
        logic [4:0] flags;
        flags = {rsp.hit, rsp.pvalid, rsp.dirty, rsp.cached, rsp.addr_err};
        check_value({name, ".valid"}, {31'b0, exp_valid}, {31'b0, rsp.valid});
        if (exp_valid) begin
            check_value({name, ".store"}, {31'b0, exp_store}, {31'b0, rsp.store});
            check_value({name, ".vaddr"}, exp_vaddr, rsp.vaddr);
            if (exp_flags[0]) begin
                check_value({name, ".addr_err"}, 32'd1, {31'b0, rsp.addr_err});
            end else if (!exp_flags[4]) begin
                // Translation is undefined on a miss
                check_value({name, ".{hit,addr_err}"}, 32'd0, {30'b0, rsp.hit, rsp.addr_err});
            end else begin
                check_value({name, ".paddr"}, exp_paddr, rsp.paddr);
                check_value({name, ".flags"}, {27'b0, exp_flags}, {27'b0, flags});
            end
        end
    endtask

    task automatic do_lookup();
        logic [31:0] v[16];
        for (int k = 0; k < 16; k++) begin
            v[k] = next_field();
        end
        cp0.asid            = 8'(v[0]);
        cp0.kernel_mode     = v[1][0];
        cp0.erl             = v[2][0];
        cp0.kseg0_cached    = v[3][0];
        fetch_req.valid     = v[4][0];
        fetch_req.store     = v[5][0];
        fetch_req.vaddr     = v[6];
        data_req.valid      = v[7][0];
        data_req.store      = v[8][0];
        data_req.vaddr      = v[9];
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
        data_req.valid  = 1'b0;
        check_port("fetch_rsp_o", v[4][0], v[5][0], v[6], v[10], 5'(v[11]), fetch_rsp);
        check_port("data_rsp_o", v[7][0], v[8][0], v[9], v[12], 5'(v[13]), data_rsp);
        check_value("exc_o", v[14], {28'b0, exc});
        check_value("badvaddr_o", v[15], badvaddr);
    endtask

    initial begin
        wait (cases_loaded);
        repeat (RESET_CYCLES + CASE_CYCLES * num_cases) @(posedge clk);
        report_failure("Watchdog expired before all cases of the case file were run");
    end

    initial begin
        logic [7:0] kind;
        seed           = 11363;
        rst            = 1'b1;
        mgmt_req_valid = 1'b0;
        mgmt_req       = '0;
        cp0            = '0;
        fetch_req      = '0;
        data_req       = '0;
        num_cases      = 0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        while (kinds.size() > 0) begin
            kind = kinds.pop_front();
            // B issues with no idle gap after the previous operation
            if (kind != "B") begin
                idle_cycles();
            end
            if ((kind == "L") || (kind == "B")) begin
                do_lookup();
            end else begin
                do_mgmt(kind);
            end
        end
        wait_ack(1'b0, "fall after the last request");
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/mmu_cases.txt ====
# W idx mask entryhi lo0 lo1 | R idx, expected mask entryhi lo0 lo1 | P entryhi, expected index
# L/B asid km erl k0c fv fs fvaddr dv ds dvaddr, expected fpaddr fflags dpaddr dflags exc badvaddr
R 7 000 00000000 00000018 00000018
W 0 000 00400005 0004001E 00040052
R 0 000 00400005 0004001E 00040052
W 1 003 00806007 000800DF 00080118
R 1 003 00800007 0008001E 00080118
W 2 000 10000022 000C0017 000C005F
R 2 000 10000022 000C0017 000C005F
W 5 000 10000005 0010001E 0010005E
P 00400005 00000000
P 00400009 80000000
P 00806007 00000001
P 10000005 00000002
P 100000AA 00000002
L 05 0 0 0 1 0 00400ABC 1 0 00401234 01000ABC 11110 01001234 11000 0 00000000
L 07 1 0 0 1 0 00801234 1 0 00805678 02001234 11110 02005678 10010 7 00805678
L 00 1 0 1 1 0 80001000 1 1 A0002000 00001000 11110 00002000 11100 0 00000000
L 00 1 1 0 1 0 9FC00000 1 0 00600010 1FC00000 11100 00600010 11100 0 00000000
L 05 0 0 0 1 0 80000000 1 1 C0000000 00000000 00001 00000000 00001 1 80000000
L 05 0 0 0 0 0 00000000 1 1 E0000000 00000000 00000 00000000 00001 5 E0000000
L 05 0 0 0 0 0 00000000 1 0 A0000000 00000000 00000 00000000 00001 4 A0000000
L 05 0 0 0 1 0 00600000 1 0 00400010 00000000 00000 01000010 11110 2 00600000
L 05 0 0 0 0 0 00000000 1 1 00700000 00000000 00000 00000000 00000 6 00700000
L 07 0 0 0 1 0 00804000 1 1 00400000 02004000 10010 00000000 00000 3 00804000
L 33 0 0 0 1 0 10001ABC 1 0 10000040 03001ABC 11110 03000040 11100 0 00000000
L 05 0 0 0 0 0 00000000 1 1 00401000 00000000 00000 01001000 11000 8 00401000
L 05 0 0 0 1 0 00A00123 0 0 00000000 00000000 00000 00000000 00000 2 00A00123
W 3 000 00A00005 0014001E 0014005E
B 05 0 0 0 1 0 00A00123 1 1 00A01456 05000123 11110 05001456 11110 0 00000000
R 3 000 00A00005 0014001E 0014005E

// ==== sim.f ====
common/mmu_pkg.sv
design/tlb/tlb_entry_array.sv
design/tlb/tlb_mgmt_ctrl.sv
design/tlb/tlb_lookup.sv
design/mmu_fault_merge.sv
design/mmu_top.sv
bench/mmu_tb.sv

// ==== Makefile ====
TOOL     := verilator
TOP      := mmu_tb
FILELIST := sim.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJDIR   := obj_dir
LOG      := sim.log
PASS     := No errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
